// File: cu_dp_mem.f
cu_dp_mem_pkg.sv
addr_xlate.sv
l1_dcache.sv
data_path_memory.sv
ldst_cu_fsm.sv
except_cu_fsm.sv
cu_dp_mem.sv
tb_checker.sv
tb_cu_dp_mem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cu_dp_mem
FILELIST  := cu_dp_mem.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "SIMULATION PASSED" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// File: tb_cu_dp_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cu_dp_mem;

	// 300 instructions, 20 cycles each, 20 ns per cycle
	localparam int WATCHDOG_NS = 300 * 20 * 20;

	logic clk_i;
	logic rst_n_i;
	logic ins_valid_i;
	cu_dp_mem_pkg::instr_u ins_i;
	logic [31:0] rs1_val_i;
	logic [31:0] rs2_val_i;
	logic vmem_on_i;
	logic [19:0] csr_root_ppn_i;
	logic abort_i;
	logic ins_rdy_o;
	logic ld_valid_o;
	logic [31:0] ld_data_o;
	logic except_raised_o;
	cu_dp_mem_pkg::except_code_t except_code_o;
	logic flush_o;
	logic [3:0] rob_head_idx_o;
	cu_dp_mem_pkg::l2arb_l2c_req_t l2_req;
	logic l2_req_rdy = 1'b0;
	cu_dp_mem_pkg::l2c_l2arb_ans_t l2_ans = '0;
	logic l2_ans_rdy;

	// L2 model state
	logic [31:0] l2_mem [cu_dp_mem_pkg::PHYS_WORDS];
	logic got_req;
	logic got_ans;
	cu_dp_mem_pkg::l2arb_l2c_req_t req_q;
	int rd_wait;
	logic [11:0] rd_idx;
	int last_word;

	cu_dp_mem #(.L1DC_LINES(8)) dut0 (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.ins_valid_i(ins_valid_i), .ins_i(ins_i),
		.rs1_val_i(rs1_val_i), .rs2_val_i(rs2_val_i),
		.vmem_on_i(vmem_on_i), .csr_root_ppn_i(csr_root_ppn_i), .abort_i(abort_i),
		.ins_rdy_o(ins_rdy_o), .ld_valid_o(ld_valid_o), .ld_data_o(ld_data_o),
		.except_raised_o(except_raised_o), .except_code_o(except_code_o),
		.flush_o(flush_o), .rob_head_idx_o(rob_head_idx_o),
		.l2arb_l2c_req_o(l2_req), .l2c_l2arb_req_rdy_i(l2_req_rdy),
		.l2c_l2arb_ans_i(l2_ans), .l2arb_l2c_ans_rdy_o(l2_ans_rdy)
	);

	tb_checker chk0 (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.ins_valid_i(ins_valid_i), .ins_i(ins_i),
		.rs1_val_i(rs1_val_i), .rs2_val_i(rs2_val_i),
		.vmem_on_i(vmem_on_i), .csr_root_ppn_i(csr_root_ppn_i), .abort_i(abort_i),
		.ins_rdy_i(ins_rdy_o), .ld_valid_i(ld_valid_o), .ld_data_i(ld_data_o),
		.except_raised_i(except_raised_o), .except_code_i(except_code_o),
		.flush_i(flush_o), .rob_head_idx_i(rob_head_idx_o),
		.l2_req_i(l2_req), .l2_req_rdy_i(l2_req_rdy),
		.l2_ans_i(l2_ans), .l2_ans_rdy_i(l2_ans_rdy)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// Word i of L2 holds 3i+1
	initial begin
		for (int i = 0; i < cu_dp_mem_pkg::PHYS_WORDS; i++) begin
			l2_mem[i] = 32'(i * 3 + 1);
		end
	end

	// Sample L2 handshakes on the rising edge
	always @(posedge clk_i) begin
		got_req <= l2_req.valid && l2_req_rdy;
		got_ans <= l2_ans.valid && l2_ans_rdy;
		req_q <= l2_req;
	end

	// L2 emulator, drives on the falling edge
	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			l2_req_rdy = 1'b0;
			l2_ans = '0;
			rd_wait = 0;
		end else begin
			// Ready low about one cycle in four
			l2_req_rdy = ($urandom % 4) != 0;
			if (got_ans) begin
				l2_ans.valid = 1'b0;
			end
			if (got_req) begin
				if (req_q.we) begin
					l2_mem[req_q.addr[13:2]] = req_q.wdata;
				end else begin
					rd_wait = 1 + int'($urandom % 4);
					rd_idx = req_q.addr[13:2];
				end
			end
			if (rd_wait > 0) begin
				rd_wait--;
				if (rd_wait == 0) begin
					l2_ans.valid = 1'b1;
					l2_ans.rdata = l2_mem[rd_idx];
				end
			end
		end
	end

	function automatic logic [31:0] load_instr(input int imm, input logic [2:0] f3,
			input logic [6:0] opc);
		logic [11:0] i12;
		i12 = 12'(imm);
		return {i12, 5'd1, f3, 5'd2, opc};
	endfunction

	function automatic logic [31:0] store_instr(input int imm);
		logic [11:0] i12;
		i12 = 12'(imm);
		return {i12[11:5], 5'd3, 5'd1, 3'b010, i12[4:0], 7'b0100011};
	endfunction

	// Issue one instruction and wait until the DUT takes the next
	task automatic issue_instr(input logic [31:0] ins, input logic [31:0] base,
			input logic [31:0] data);
		while (!ins_rdy_o) @(negedge clk_i);
		ins_i = ins;
		rs1_val_i = base;
		rs2_val_i = data;
		ins_valid_i = 1'b1;
		@(negedge clk_i);
		ins_valid_i = 1'b0;
		// Abort zero to two cycles after the flush
		while (!ins_rdy_o) begin
			if (flush_o) begin
				repeat ($urandom % 3) @(negedge clk_i);
				abort_i = 1'b1;
			end
			@(negedge clk_i);
		end
		abort_i = 1'b0;
	endtask

	// Aligned access to a byte address, with a random offset split
	task automatic aligned_access(input logic store, input logic [31:0] byte_addr);
		int imm;
		imm = (int'($urandom % 32) - 16) * 4;
		if (store) begin
			issue_instr(store_instr(imm), byte_addr - 32'(imm), $urandom);
		end else begin
			issue_instr(load_instr(imm, 3'b010, 7'b0000011), byte_addr - 32'(imm), 32'h0);
		end
	endtask

	task automatic random_traffic(input int count, input int span_words);
		int w;
		for (int n = 0; n < count; n++) begin
			// Reuse the last word now and then to hit the cache
			w = (($urandom % 4) == 0) ? last_word : int'($urandom % span_words);
			last_word = w;
			aligned_access(($urandom % 2) == 1, 32'(w * 4));
		end
	endtask

	task automatic inject_faults(input int count);
		int kind;
		for (int n = 0; n < count; n++) begin
			kind = int'($urandom % 4);
			case (kind)
				0: issue_instr(load_instr(0, 3'b010, 7'b0000011),
					32'($urandom % 4096) * 4 + 1 + 32'($urandom % 3), 0);
				1: issue_instr(store_instr(4), 32'($urandom % 4000) * 4 + 2, $urandom);
				2: aligned_access(($urandom % 2) == 1, 32'h4000 + 32'($urandom % 1024) * 4);
				default: issue_instr(load_instr(0, 3'(($urandom % 2) * 4),
					(($urandom % 2) == 1) ? 7'b0010011 : 7'b0000011), 32'h100, 0);
			endcase
		end
	endtask

	initial begin
		void'($urandom(10));
		rst_n_i = 1'b0;
		ins_valid_i = 1'b0;
		ins_i = '0;
		rs1_val_i = '0;
		rs2_val_i = '0;
		vmem_on_i = 1'b0;
		csr_root_ppn_i = '0;
		abort_i = 1'b0;
		last_word = 0;
		repeat (16) @(negedge clk_i);
		rst_n_i = 1'b1;
		repeat (2) @(negedge clk_i);
		random_traffic(200, cu_dp_mem_pkg::PHYS_WORDS);
		// Two pages of offset leave 2048 words in range
		vmem_on_i = 1'b1;
		csr_root_ppn_i = 20'd2;
		random_traffic(60, 2048);
		inject_faults(20);
		vmem_on_i = 1'b0;
		inject_faults(10);
		repeat (5) @(negedge clk_i);
		chk0.final_check();
		$display("Checks done, errors: %0d", chk0.errors);
		if (chk0.errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS * 1ns);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic ins_valid_i,
	input wire logic [31:0] ins_i,
	input wire logic [31:0] rs1_val_i,
	input wire logic [31:0] rs2_val_i,
	input wire logic vmem_on_i,
	input wire logic [19:0] csr_root_ppn_i,
	input wire logic abort_i,
	input wire logic ins_rdy_i,
	input wire logic ld_valid_i,
	input wire logic [31:0] ld_data_i,
	input wire logic except_raised_i,
	input wire cu_dp_mem_pkg::except_code_t except_code_i,
	input wire logic flush_i,
	input wire logic [3:0] rob_head_idx_i,
	input wire cu_dp_mem_pkg::l2arb_l2c_req_t l2_req_i,
	input wire logic l2_req_rdy_i,
	input wire cu_dp_mem_pkg::l2c_l2arb_ans_t l2_ans_i,
	input wire logic l2_ans_rdy_i
);

	int errors = 0;
	int cyc = 0;
	logic [31:0] shadow [4096];
	logic was_up = 1'b0;
	// Access in flight
	logic pend = 1'b0;
	cu_dp_mem_pkg::except_code_t p_code;
	logic p_store;
	logic [31:0] p_paddr;
	logic [31:0] p_wdata;
	logic [31:0] p_val;
	int p_acc;
	int p_l2;
	logic p_repeat;
	logic last_ld_ok = 1'b0;
	logic [31:0] last_ld_addr;
	logic [3:0] commits = '0;
	logic flush_due = 1'b0;
	logic hold_abort = 1'b0;
	logic req_wait = 1'b0;
	cu_dp_mem_pkg::l2arb_l2c_req_t req_prev;

	initial begin
		for (int i = 0; i < 4096; i++) begin
			shadow[i] = 32'(i * 3 + 1);
		end
	end

	task automatic log_error(input string msg);
		errors++;
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	// RISC-V LW/SW semantics with base-page translation
	function automatic cu_dp_mem_pkg::except_code_t expect_access(input logic [31:0] ins,
			input logic [31:0] rs1, input logic vmem, input logic [19:0] ppn,
			output logic [31:0] paddr, output logic store, output logic [31:0] value);
		logic [6:0] opc;
		logic [31:0] imm;
		logic [31:0] va;
		opc = ins[6:0];
		store = (opc == 7'h23);
		paddr = '0;
		value = '0;
		if ((opc != 7'h03 && opc != 7'h23) || ins[14:12] != 3'b010) begin
			return cu_dp_mem_pkg::EXC_ACCESS_FAULT;
		end
		imm = store ? {{20{ins[31]}}, ins[31:25], ins[11:7]} : {{20{ins[31]}}, ins[31:20]};
		va = rs1 + imm;
		paddr = vmem ? va + {ppn, 12'h000} : va;
		if (va[1:0] != 2'b00) begin
			return store ? cu_dp_mem_pkg::EXC_ST_MISALIGN : cu_dp_mem_pkg::EXC_LD_MISALIGN;
		end
		if (paddr >= 32'h4000) begin
			return cu_dp_mem_pkg::EXC_ACCESS_FAULT;
		end
		value = shadow[paddr[13:2]];
		return cu_dp_mem_pkg::EXC_NONE;
	endfunction

	// A store must have made exactly one L2 write
	task automatic close_access();
		if (pend && p_code == cu_dp_mem_pkg::EXC_NONE) begin
			if (p_store && p_l2 != 1) log_error($sformatf("store made %0d L2 writes", p_l2));
			if (!p_store) log_error("load finished without ld_valid_o");
		end
		// Faulting access ended with no exception pulse
		if (pend && p_code != cu_dp_mem_pkg::EXC_NONE) begin
			log_error("expected exception was not raised");
		end
		pend = 1'b0;
	endtask

	task automatic final_check();
		close_access();
		if (rob_head_idx_i != commits) log_error("commit count mismatch at the end");
		if (hold_abort) log_error("exception never aborted");
	endtask

	always @(posedge clk_i) begin
		cyc++;
		if (!rst_n_i) begin
			pend = 1'b0;
			was_up = 1'b0;
		end else begin
			if (!was_up && (!ins_rdy_i || ld_valid_i || except_raised_i || flush_i ||
					l2_req_i.valid || l2_ans_rdy_i || rob_head_idx_i != 4'd0)) begin
				log_error("control outputs wrong after reset");
			end
			was_up = 1'b1;
			if (req_wait && l2_req_i != req_prev) log_error("L2 request changed while stalled");
			req_wait = l2_req_i.valid && !l2_req_rdy_i;
			req_prev = l2_req_i;
			// Answers only come for a pending fill
			if (l2_ans_i.valid && !l2_ans_rdy_i) log_error("L2 answer left waiting by the cache");
			if (l2_req_i.valid && l2_req_rdy_i) begin
				p_l2++;
				if (!pend || p_code != cu_dp_mem_pkg::EXC_NONE) begin
					log_error("L2 request without a legal access");
				end else if (l2_req_i.we != p_store || l2_req_i.addr != p_paddr ||
						(p_store && l2_req_i.wdata != p_wdata)) begin
					log_error($sformatf("L2 request addr %h, expected %h", l2_req_i.addr, p_paddr));
				end else if (p_repeat) begin
					log_error("repeated load went to L2");
				end
			end
			if (ld_valid_i) begin
				if (!pend || p_store || p_code != cu_dp_mem_pkg::EXC_NONE) begin
					log_error("unexpected ld_valid_o");
				end else begin
					if (ld_data_i != p_val) begin
						log_error($sformatf("load %h got %h, expected %h", p_paddr, ld_data_i, p_val));
					end
					// Rises 3 edges after acceptance, seen one sample later
					if (p_repeat && cyc - p_acc != 4) log_error("repeated load latency wrong");
					last_ld_ok = 1'b1;
					last_ld_addr = p_paddr;
				end
				pend = 1'b0;
			end
			if (flush_due) begin
				if (!flush_i) log_error("flush_o missing after exception");
				flush_due = 1'b0;
			end else if (flush_i) begin
				log_error("flush_o without exception");
			end
			if (except_raised_i) begin
				if (!pend || p_code == cu_dp_mem_pkg::EXC_NONE) begin
					log_error("unexpected exception");
				end else if (except_code_i != p_code) begin
					log_error($sformatf("exception code %0d, expected %0d", except_code_i, p_code));
				end
				pend = 1'b0;
				flush_due = 1'b1;
				hold_abort = 1'b1;
			end
			if (hold_abort && ins_rdy_i) log_error("ins_rdy_o high before abort");
			if (abort_i) hold_abort = 1'b0;
			if (ins_valid_i && ins_rdy_i) begin
				close_access();
				if (rob_head_idx_i != commits) log_error("rob_head_idx_o wrong");
				p_code = expect_access(ins_i, rs1_val_i, vmem_on_i, csr_root_ppn_i,
					p_paddr, p_store, p_val);
				p_wdata = rs2_val_i;
				p_acc = cyc;
				p_l2 = 0;
				pend = 1'b1;
				p_repeat = (p_code == cu_dp_mem_pkg::EXC_NONE) && !p_store && last_ld_ok &&
					(last_ld_addr == p_paddr);
				if (p_code == cu_dp_mem_pkg::EXC_NONE) begin
					commits = commits + 4'd1;
					if (p_store) begin
						shadow[p_paddr[13:2]] = rs2_val_i;
						last_ld_ok = 1'b0;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: cu_dp_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cu_dp_mem #(
	parameter int L1DC_LINES = 8
) (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	// Instruction side
	input  wire logic ins_valid_i,
	input  wire cu_dp_mem_pkg::instr_u ins_i,
	input  wire logic [cu_dp_mem_pkg::XLEN-1:0] rs1_val_i,
	input  wire logic [cu_dp_mem_pkg::XLEN-1:0] rs2_val_i,
	// Configuration and abort
	input  wire logic vmem_on_i,
	input  wire logic [cu_dp_mem_pkg::PPN_LEN-1:0] csr_root_ppn_i,
	input  wire logic abort_i,
	// Results
	output logic ins_rdy_o,
	output logic ld_valid_o,
	output logic [cu_dp_mem_pkg::XLEN-1:0] ld_data_o,
	output logic except_raised_o,
	output cu_dp_mem_pkg::except_code_t except_code_o,
	output logic flush_o,
	output logic [cu_dp_mem_pkg::ROB_IDX_LEN-1:0] rob_head_idx_o,
	// L2 channel
	output cu_dp_mem_pkg::l2arb_l2c_req_t l2arb_l2c_req_o,
	input  wire logic l2c_l2arb_req_rdy_i,
	input  wire cu_dp_mem_pkg::l2c_l2arb_ans_t l2c_l2arb_ans_i,
	output logic l2arb_l2c_ans_rdy_o
);

	cu_dp_mem_pkg::mem_req_t mem_req;
	logic mem_done;
	logic [cu_dp_mem_pkg::XLEN-1:0] mem_rdata;
	logic mem_except;
	cu_dp_mem_pkg::except_code_t mem_except_code;
	logic decode_except;
	logic ldst_busy;
	logic exc_stall;

	// New instruction only when neither FSM holds the pipe
	assign ins_rdy_o = !ldst_busy && !exc_stall;

	ldst_cu_fsm u_ldst_cu_fsm (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.ins_valid_i     (ins_valid_i),
		.ins_i           (ins_i),
		.rs1_val_i       (rs1_val_i),
		.rs2_val_i       (rs2_val_i),
		.stall_i         (exc_stall),
		.mem_req_o       (mem_req),
		.mem_done_i      (mem_done),
		.mem_rdata_i     (mem_rdata),
		.mem_except_i    (mem_except),
		.decode_except_o (decode_except),
		.busy_o          (ldst_busy),
		.ld_valid_o      (ld_valid_o),
		.ld_data_o       (ld_data_o),
		.rob_head_idx_o  (rob_head_idx_o)
	);

	except_cu_fsm u_except_cu_fsm (
		.clk_i             (clk_i),
		.rst_n_i           (rst_n_i),
		.mem_except_i      (mem_except),
		.mem_except_code_i (mem_except_code),
		.decode_except_i   (decode_except),
		.abort_i           (abort_i),
		.stall_o           (exc_stall),
		.except_raised_o   (except_raised_o),
		.except_code_o     (except_code_o),
		.flush_o           (flush_o)
	);

	data_path_memory #(
		.L1DC_LINES (L1DC_LINES)
	) u_data_path_memory (
		.clk_i               (clk_i),
		.rst_n_i             (rst_n_i),
		.flush_i             (flush_o),
		.mem_req_i           (mem_req),
		.vmem_on_i           (vmem_on_i),
		.csr_root_ppn_i      (csr_root_ppn_i),
		.mem_done_o          (mem_done),
		.mem_rdata_o         (mem_rdata),
		.mem_except_o        (mem_except),
		.mem_except_code_o   (mem_except_code),
		.l2arb_l2c_req_o     (l2arb_l2c_req_o),
		.l2c_l2arb_req_rdy_i (l2c_l2arb_req_rdy_i),
		.l2c_l2arb_ans_i     (l2c_l2arb_ans_i),
		.l2arb_l2c_ans_rdy_o (l2arb_l2c_ans_rdy_o)
	);

endmodule

`default_nettype wire

// File: except_cu_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module except_cu_fsm (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	input  wire logic mem_except_i,
	input  wire cu_dp_mem_pkg::except_code_t mem_except_code_i,
	input  wire logic decode_except_i,
	input  wire logic abort_i,
	output logic stall_o,
	output logic except_raised_o,
	output cu_dp_mem_pkg::except_code_t except_code_o,
	output logic flush_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RAISE,
		ST_FLUSH,
		ST_HALT
	} state_t;

	state_t state_q;
	logic exc_in;

	assign exc_in = mem_except_i || decode_except_i;

	// Moore outputs
	assign except_raised_o = (state_q == ST_RAISE);
	assign flush_o = (state_q == ST_FLUSH);
	assign stall_o = (state_q != ST_IDLE);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			except_code_o <= cu_dp_mem_pkg::EXC_NONE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (exc_in) begin
						state_q <= ST_RAISE;
						// Decode traps are always access faults
						except_code_o <= decode_except_i ?
							cu_dp_mem_pkg::EXC_ACCESS_FAULT : mem_except_code_i;
					end
				end
				ST_RAISE: state_q <= ST_FLUSH;
				// Abort may already come with the flush
				ST_FLUSH: state_q <= abort_i ? ST_IDLE : ST_HALT;
				ST_HALT: begin
					if (abort_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Single flush per exception
	a_flush_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		flush_o |=> !flush_o);

endmodule

`default_nettype wire

// File: ldst_cu_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ldst_cu_fsm (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	input  wire logic ins_valid_i,
	input  wire cu_dp_mem_pkg::instr_u ins_i,
	input  wire logic [cu_dp_mem_pkg::XLEN-1:0] rs1_val_i,
	input  wire logic [cu_dp_mem_pkg::XLEN-1:0] rs2_val_i,
	input  wire logic stall_i,
	output cu_dp_mem_pkg::mem_req_t mem_req_o,
	input  wire logic mem_done_i,
	input  wire logic [cu_dp_mem_pkg::XLEN-1:0] mem_rdata_i,
	input  wire logic mem_except_i,
	output logic decode_except_o,
	output logic busy_o,
	output logic ld_valid_o,
	output logic [cu_dp_mem_pkg::XLEN-1:0] ld_data_o,
	output logic [cu_dp_mem_pkg::ROB_IDX_LEN-1:0] rob_head_idx_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT
	} state_t;

	state_t state_q;
	logic [cu_dp_mem_pkg::ILEN-1:0] ins_q;
	logic [cu_dp_mem_pkg::XLEN-1:0] rs1_q;
	logic [cu_dp_mem_pkg::XLEN-1:0] rs2_q;
	cu_dp_mem_pkg::instr_u dec;
	logic accept;
	logic is_load;
	logic is_store;
	logic [11:0] imm12;
	logic [cu_dp_mem_pkg::XLEN-1:0] eff_addr;

	assign accept = ins_valid_i && !stall_i && (state_q == ST_IDLE);
	assign busy_o = (state_q != ST_IDLE);

	// Same word, read as I-type or S-type
	assign dec = ins_q;
	assign is_load = (dec.ld.opcode == cu_dp_mem_pkg::OPC_LOAD) &&
		(dec.ld.funct3 == cu_dp_mem_pkg::F3_WORD);
	assign is_store = (dec.st.opcode == cu_dp_mem_pkg::OPC_STORE) &&
		(dec.st.funct3 == cu_dp_mem_pkg::F3_WORD);
	assign imm12 = is_store ? {dec.st.imm_hi, dec.st.imm_lo} : dec.ld.imm;
	assign eff_addr = rs1_q + {{(cu_dp_mem_pkg::XLEN-12){imm12[11]}}, imm12};

	// Anything else traps straight from decode
	assign decode_except_o = (state_q == ST_ISSUE) && !is_load && !is_store;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			mem_req_o.valid <= 1'b0;
			ld_valid_o <= 1'b0;
			rob_head_idx_o <= '0;
		end else begin
			ld_valid_o <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						state_q <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					// One-cycle request strobe
					mem_req_o.valid <= is_load || is_store;
					state_q <= (is_load || is_store) ? ST_WAIT : ST_IDLE;
				end
				ST_WAIT: begin
					mem_req_o.valid <= 1'b0;
					if (mem_done_i) begin
						state_q <= ST_IDLE;
						rob_head_idx_o <= rob_head_idx_o + 1'b1;
						ld_valid_o <= (mem_req_o.ldst == cu_dp_mem_pkg::LDST_LW);
					end else if (mem_except_i) begin
						// Trapped access, no commit
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
		// Operands of the accepted instruction
		if (accept) begin
			ins_q <= ins_i;
			rs1_q <= rs1_val_i;
			rs2_q <= rs2_val_i;
		end
		if (state_q == ST_ISSUE) begin
			mem_req_o.ldst <= is_load ? cu_dp_mem_pkg::LDST_LW : cu_dp_mem_pkg::LDST_SW;
			mem_req_o.vaddr <= eff_addr;
			mem_req_o.wdata <= rs2_q;
		end
		if (mem_done_i) begin
			ld_data_o <= mem_rdata_i;
		end
	end

	// Only one request per instruction
	a_no_req_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		state_q == ST_WAIT |=> !$rose(mem_req_o.valid));

endmodule

`default_nettype wire

// File: data_path_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_path_memory #(
	parameter int L1DC_LINES = 8
) (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	input  wire logic flush_i,
	input  wire cu_dp_mem_pkg::mem_req_t mem_req_i,
	input  wire logic vmem_on_i,
	input  wire logic [cu_dp_mem_pkg::PPN_LEN-1:0] csr_root_ppn_i,
	output logic mem_done_o,
	output logic [cu_dp_mem_pkg::XLEN-1:0] mem_rdata_o,
	output logic mem_except_o,
	output cu_dp_mem_pkg::except_code_t mem_except_code_o,
	output cu_dp_mem_pkg::l2arb_l2c_req_t l2arb_l2c_req_o,
	input  wire logic l2c_l2arb_req_rdy_i,
	input  wire cu_dp_mem_pkg::l2c_l2arb_ans_t l2c_l2arb_ans_i,
	output logic l2arb_l2c_ans_rdy_o
);

	cu_dp_mem_pkg::mem_req_t preq;
	logic xlate_except;
	cu_dp_mem_pkg::except_code_t xlate_code;

	addr_xlate u_addr_xlate (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.req_i          (mem_req_i),
		.vmem_on_i      (vmem_on_i),
		.csr_root_ppn_i (csr_root_ppn_i),
		.preq_o         (preq),
		.except_o       (xlate_except),
		.except_code_o  (xlate_code)
	);

	// Faulting requests never reach the cache
	l1_dcache #(
		.L1DC_LINES (L1DC_LINES)
	) u_l1_dcache (
		.clk_i               (clk_i),
		.rst_n_i             (rst_n_i),
		.flush_i             (flush_i),
		.preq_i              (preq),
		.done_o              (mem_done_o),
		.rdata_o             (mem_rdata_o),
		.l2arb_l2c_req_o     (l2arb_l2c_req_o),
		.l2c_l2arb_req_rdy_i (l2c_l2arb_req_rdy_i),
		.l2c_l2arb_ans_i     (l2c_l2arb_ans_i),
		.l2arb_l2c_ans_rdy_o (l2arb_l2c_ans_rdy_o)
	);

	// Code reads as none outside the exception pulse
	assign mem_except_o = xlate_except;
	assign mem_except_code_o = xlate_except ? xlate_code : cu_dp_mem_pkg::EXC_NONE;

endmodule

`default_nettype wire

// File: l1_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_dcache #(
	parameter int L1DC_LINES = 8
) (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	input  wire logic flush_i,
	input  wire cu_dp_mem_pkg::mem_req_t preq_i,
	output logic done_o,
	output logic [cu_dp_mem_pkg::XLEN-1:0] rdata_o,
	output cu_dp_mem_pkg::l2arb_l2c_req_t l2arb_l2c_req_o,
	input  wire logic l2c_l2arb_req_rdy_i,
	input  wire cu_dp_mem_pkg::l2c_l2arb_ans_t l2c_l2arb_ans_i,
	output logic l2arb_l2c_ans_rdy_o
);

	localparam int IDX_W = $clog2(L1DC_LINES);
	localparam int TAG_W = cu_dp_mem_pkg::XLEN - 2 - IDX_W;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_FILL
	} state_t;

	state_t state_q;
	logic [L1DC_LINES-1:0] valid_q;
	logic [TAG_W-1:0] tag_q [L1DC_LINES];
	logic [cu_dp_mem_pkg::XLEN-1:0] data_q [L1DC_LINES];
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] req_tag;
	logic [IDX_W-1:0] fill_idx;
	logic hit;
	logic accept;
	logic is_store;
	logic hit_done;
	logic wr_done;
	logic fill_done;

	// Word-indexed line select
	assign idx = preq_i.vaddr[2 +: IDX_W];
	assign req_tag = preq_i.vaddr[cu_dp_mem_pkg::XLEN-1 -: TAG_W];
	// Fill line comes from the address held in the L2 request
	assign fill_idx = l2arb_l2c_req_o.addr[2 +: IDX_W];
	assign hit = valid_q[idx] && (tag_q[idx] == req_tag);

	// A flush cycle drops the incoming request
	assign accept = (state_q == ST_IDLE) && preq_i.valid && !flush_i;
	assign is_store = (preq_i.ldst == cu_dp_mem_pkg::LDST_SW);

	assign hit_done = accept && !is_store && hit;
	assign wr_done = (state_q == ST_REQ) && l2arb_l2c_req_o.we && l2c_l2arb_req_rdy_i;
	assign fill_done = (state_q == ST_FILL) && l2c_l2arb_ans_i.valid;

	assign done_o = hit_done || wr_done || fill_done;
	assign rdata_o = (state_q == ST_FILL) ? l2c_l2arb_ans_i.rdata : data_q[idx];
	assign l2arb_l2c_ans_rdy_o = (state_q == ST_FILL);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			valid_q <= '0;
			l2arb_l2c_req_o.valid <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					// Misses and all stores go to L2
					if (accept && !hit_done) begin
						l2arb_l2c_req_o.valid <= 1'b1;
						state_q <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (l2c_l2arb_req_rdy_i) begin
						l2arb_l2c_req_o.valid <= 1'b0;
						state_q <= l2arb_l2c_req_o.we ? ST_IDLE : ST_FILL;
					end
				end
				ST_FILL: begin
					if (fill_done) begin
						valid_q[fill_idx] <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
		// Request payload held until the transfer
		if (accept) begin
			l2arb_l2c_req_o.we <= is_store;
			l2arb_l2c_req_o.addr <= preq_i.vaddr;
			l2arb_l2c_req_o.wdata <= preq_i.wdata;
		end
		// Write-through, no allocate on a store miss
		if (accept && is_store && hit) begin
			data_q[idx] <= preq_i.wdata;
		end
		if (fill_done) begin
			tag_q[fill_idx] <= l2arb_l2c_req_o.addr[cu_dp_mem_pkg::XLEN-1 -: TAG_W];
			data_q[fill_idx] <= l2c_l2arb_ans_i.rdata;
		end
	end

	// L2 request stable under back-pressure
	a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		l2arb_l2c_req_o.valid && !l2c_l2arb_req_rdy_i |=> $stable(l2arb_l2c_req_o));

endmodule

`default_nettype wire

// File: addr_xlate.sv
`timescale 1ns/1ps
`default_nettype none

module addr_xlate (
	input  wire logic clk_i,
	input  wire logic rst_n_i,
	input  wire cu_dp_mem_pkg::mem_req_t req_i,
	input  wire logic vmem_on_i,
	input  wire logic [cu_dp_mem_pkg::PPN_LEN-1:0] csr_root_ppn_i,
	output cu_dp_mem_pkg::mem_req_t preq_o,
	output logic except_o,
	output cu_dp_mem_pkg::except_code_t except_code_o
);

	logic [cu_dp_mem_pkg::XLEN-1:0] paddr;
	logic [cu_dp_mem_pkg::PPN_LEN-1:0] ppn;
	logic misalign;
	logic out_of_range;
	cu_dp_mem_pkg::except_code_t code;

	// Page number shifted by the root PPN, offset untouched
	assign ppn = req_i.vaddr[cu_dp_mem_pkg::XLEN-1:cu_dp_mem_pkg::PAGE_OFF] + csr_root_ppn_i;
	assign paddr = vmem_on_i ?
		{ppn, req_i.vaddr[cu_dp_mem_pkg::PAGE_OFF-1:0]} : req_i.vaddr;

	assign misalign = (req_i.vaddr[1:0] != 2'b00);
	assign out_of_range = (paddr >= cu_dp_mem_pkg::PHYS_LIMIT);

	// Misalignment wins over the range check
	always_comb begin
		code = cu_dp_mem_pkg::EXC_NONE;
		if (misalign) begin
			code = (req_i.ldst == cu_dp_mem_pkg::LDST_SW) ?
				cu_dp_mem_pkg::EXC_ST_MISALIGN : cu_dp_mem_pkg::EXC_LD_MISALIGN;
		end else if (out_of_range || req_i.ldst == cu_dp_mem_pkg::LDST_NONE) begin
			code = cu_dp_mem_pkg::EXC_ACCESS_FAULT;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			preq_o.valid <= 1'b0;
			except_o <= 1'b0;
			except_code_o <= cu_dp_mem_pkg::EXC_NONE;
		end else begin
			// Either a clean physical request or an exception, never both
			preq_o.valid <= req_i.valid && (code == cu_dp_mem_pkg::EXC_NONE);
			except_o <= req_i.valid && (code != cu_dp_mem_pkg::EXC_NONE);
			except_code_o <= code;
		end
		preq_o.ldst <= req_i.ldst;
		preq_o.vaddr <= paddr;
		preq_o.wdata <= req_i.wdata;
	end

endmodule

`default_nettype wire

// File: cu_dp_mem_pkg.sv
`default_nettype none

package cu_dp_mem_pkg;

	// Data, address and instruction widths
	localparam int XLEN = 32;
	localparam int ILEN = 32;

	// 4 KiB pages
	localparam int PAGE_OFF = 12;
	localparam int PPN_LEN = 20;

	// Physical memory size in words, and the first byte address beyond it
	localparam int PHYS_WORDS = 4096;
	localparam logic [XLEN-1:0] PHYS_LIMIT = XLEN'(PHYS_WORDS * 4);

	// Commit counter width
	localparam int ROB_IDX_LEN = 4;

	// Major opcodes and funct3 of the word accesses
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [2:0] F3_WORD = 3'b010;

	typedef enum logic [1:0] {
		EXC_NONE,
		EXC_LD_MISALIGN,
		EXC_ST_MISALIGN,
		// Out of range address, or opcode/funct3 not supported
		EXC_ACCESS_FAULT
	} except_code_t;

	typedef enum logic [1:0] {
		LDST_NONE,
		LDST_LW,
		LDST_SW
	} ldst_type_t;

	// I-type load word
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} load_fmt_t;

	// S-type store word
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} store_fmt_t;

	// Opcode field sits in the same bits in both views
	typedef union packed {
		load_fmt_t ld;
		store_fmt_t st;
	} instr_u;

	// L1 to L2 request
	typedef struct packed {
		logic valid;
		logic we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} l2arb_l2c_req_t;

	// L2 to L1 answer
	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] rdata;
	} l2c_l2arb_ans_t;

	// Access request from control to datapath
	// vaddr carries the physical address after translation
	typedef struct packed {
		logic valid;
		ldst_type_t ldst;
		logic [XLEN-1:0] vaddr;
		logic [XLEN-1:0] wdata;
	} mem_req_t;

endpackage

`default_nettype wire
